// File: hdl/rvIsaPkg.sv
/* RV32I subset ISA definitions */
package rvIsaPkg;

	parameter int xlen = 32;

	typedef logic [xlen-1:0] word_t;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		rType      = 7'b0110011,
		iTypeLogic = 7'b0010011,
		iTypeLoad  = 7'b0000011,
		sType      = 7'b0100011,
		bType      = 7'b1100011,
		jType      = 7'b1101111
	} opcode_t;

	// funct3 encodings shared by R-type and I-type logic
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

	// operation actually performed by the ALU
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOp_t;

	// request from the FSM, refined by the funct fields
	typedef enum logic [1:0] {
		addOnly   = 2'b00,
		branchSub = 2'b01,
		rFunct    = 2'b10,
		iFunct    = 2'b11
	} aluCtrl_t;

endpackage

// File: hdl/rvCtrlPkg.sv
/* Core control and APB types */
package rvCtrlPkg;

	typedef enum logic [3:0] {
		stIdle,
		stFetch,
		stDecode,
		stExecuteR,
		stExecuteI,
		stUncondJump,
		stMemAdr,
		stMemRead,
		stMemWrite,
		stMemWb,
		stAluWb,
		stBranchIfEq,
		stIllegal
	} fsmState_t;

	typedef enum logic [1:0] {srcAPc, srcAOldPc, srcARd1} aluSrcA_t;
	typedef enum logic [1:0] {srcBRd2, srcBImm, srcBFour} aluSrcB_t;
	typedef enum logic [1:0] {resAluOut, resMemData, resAluResult} resultSrc_t;

	// all zero means no write of any kind
	typedef struct packed {
		logic adrSrc;
		logic irWrite;
		logic regWrite;
		logic pcUpdate;
		logic memWrite;
		aluSrcA_t aluSrcA;
		aluSrcB_t aluSrcB;
		rvIsaPkg::aluCtrl_t aluCtrl;
		resultSrc_t resultSrc;
	} ctrlSignals_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		rvIsaPkg::word_t pwdata;
	} apbReq_t;

	typedef struct packed {
		rvIsaPkg::word_t prdata;
		logic pready;
		logic pslverr;
	} apbRsp_t;

endpackage

// File: hdl/aluUnit.sv
/* ALU decoder and ALU */
`timescale 1ns/1ps

module aluUnit (
	input rvIsaPkg::aluCtrl_t aluCtrl,
	input logic [2:0] funct3,
	input logic funct7b5,
	input rvIsaPkg::word_t srcA,
	input rvIsaPkg::word_t srcB,
	output rvIsaPkg::word_t result,
	output logic zero
);
	import rvIsaPkg::*;

	aluOp_t aluOp;

	always_comb begin
		case (aluCtrl)
			addOnly: aluOp = aluAdd;
			branchSub: aluOp = aluSub;
			default: begin
				case (funct3)
					// sub exists only in R-type
					f3AddSub: aluOp = (aluCtrl == rFunct && funct7b5) ? aluSub : aluAdd;
					f3Slt: aluOp = aluSlt;
					f3Or: aluOp = aluOr;
					f3And: aluOp = aluAnd;
					default: aluOp = aluAdd;
				endcase
			end
		endcase
	end

	always_comb begin
		case (aluOp)
			aluSub: result = srcA - srcB;
			aluAnd: result = srcA & srcB;
			aluOr: result = srcA | srcB;
			aluSlt: result = ($signed(srcA) < $signed(srcB)) ? word_t'(1) : '0;
			default: result = srcA + srcB;
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: hdl/regFile.sv
/* Integer register file */
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic reset,
	input logic we,
	input logic [4:0] ra1,
	input logic [4:0] ra2,
	input logic [4:0] wa,
	input rvIsaPkg::word_t wd,
	output rvIsaPkg::word_t rd1,
	output rvIsaPkg::word_t rd2
);
	import rvIsaPkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// x0 always reads zero
	assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// File: hdl/coreDatapath.sv
/* Multicycle core datapath */
`timescale 1ns/1ps

module coreDatapath (
	input logic clk,
	input logic reset,
	input rvCtrlPkg::ctrlSignals_t ctrl,
	input rvIsaPkg::word_t memRdata,
	output rvIsaPkg::word_t memAddr,
	output rvIsaPkg::word_t memWdata,
	output logic memWe,
	output rvIsaPkg::opcode_t opcode,
	output logic zero
);
	import rvIsaPkg::*;
	import rvCtrlPkg::*;

	word_t pcReg;
	word_t oldPcReg;
	word_t irReg;
	logic irLoad;
	word_t aReg;
	word_t bReg;
	word_t aluOutReg;
	word_t instr;
	word_t rd1Val;
	word_t rd2Val;
	word_t immVal;
	word_t srcA;
	word_t srcB;
	word_t aluResult;
	word_t result;

	// synchronous memory returns the fetched word during decode,
	// so decode sees it directly and IR holds it from then on
	assign instr = irLoad ? memRdata : irReg;
	assign opcode = opcode_t'(instr[6:0]);

	always_ff @(posedge clk) begin
		if (reset) begin
			pcReg <= '0;
			irLoad <= 1'b0;
		end else begin
			irLoad <= ctrl.irWrite;
			if (ctrl.pcUpdate) begin
				pcReg <= result;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.irWrite) begin
			oldPcReg <= pcReg;
		end
		if (irLoad) begin
			irReg <= memRdata;
		end
		aReg <= rd1Val;
		bReg <= rd2Val;
		aluOutReg <= aluResult;
	end

	regFile regs0 (
		.clk(clk),
		.reset(reset),
		.we(ctrl.regWrite),
		.ra1(instr[19:15]),
		.ra2(instr[24:20]),
		.wa(instr[11:7]),
		.wd(result),
		.rd1(rd1Val),
		.rd2(rd2Val)
	);

	// immediate format follows the opcode
	always_comb begin
		case (opcode)
			iTypeLogic, iTypeLoad: immVal = {{20{instr[31]}}, instr[31:20]};
			sType: immVal = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			bType: immVal = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
				instr[11:8], 1'b0};
			jType: immVal = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
				instr[30:21], 1'b0};
			default: immVal = '0;
		endcase
	end

	always_comb begin
		case (ctrl.aluSrcA)
			srcAOldPc: srcA = oldPcReg;
			srcARd1: srcA = aReg;
			default: srcA = pcReg;
		endcase
		case (ctrl.aluSrcB)
			srcBImm: srcB = immVal;
			srcBFour: srcB = word_t'(4);
			default: srcB = bReg;
		endcase
	end

	aluUnit alu0 (
		.aluCtrl(ctrl.aluCtrl),
		.funct3(instr[14:12]),
		.funct7b5(instr[30]),
		.srcA(srcA),
		.srcB(srcB),
		.result(aluResult),
		.zero(zero)
	);

	// memory output register doubles as the data register
	always_comb begin
		case (ctrl.resultSrc)
			resMemData: result = memRdata;
			resAluResult: result = aluResult;
			default: result = aluOutReg;
		endcase
	end

	assign memAddr = ctrl.adrSrc ? aluOutReg : pcReg;
	assign memWdata = bReg;
	assign memWe = ctrl.memWrite;

endmodule

// File: hdl/controlFsm.sv
/* Multicycle control FSM */
`timescale 1ns/1ps

module controlFsm (
	input logic clk,
	input logic reset,
	input logic run,
	input rvIsaPkg::opcode_t opcode,
	input logic zero,
	output rvCtrlPkg::ctrlSignals_t ctrl,
	output logic retire,
	output logic idle,
	output logic illegal
);
	import rvIsaPkg::*;
	import rvCtrlPkg::*;

	fsmState_t state;
	fsmState_t nextState;
	fsmState_t endState;

	// where an instruction goes once it is done
	assign endState = run ? stFetch : stIdle;

	always_comb begin
		case (state)
			stIdle: nextState = run ? stFetch : stIdle;
			stFetch: nextState = stDecode;
			stDecode: begin
				case (opcode)
					rType: nextState = stExecuteR;
					iTypeLogic: nextState = stExecuteI;
					iTypeLoad, sType: nextState = stMemAdr;
					bType: nextState = stBranchIfEq;
					jType: nextState = stUncondJump;
					default: nextState = stIllegal;
				endcase
			end
			stExecuteR: nextState = stAluWb;
			stExecuteI: nextState = stAluWb;
			stUncondJump: nextState = stAluWb;
			stMemAdr: nextState = (opcode == iTypeLoad) ? stMemRead : stMemWrite;
			stMemRead: nextState = stMemWb;
			stMemWb: nextState = endState;
			stMemWrite: nextState = endState;
			stAluWb: nextState = endState;
			stBranchIfEq: nextState = endState;
			// sticky until software drops run
			stIllegal: nextState = run ? stIllegal : stIdle;
			default: nextState = stIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		ctrl = '0;
		case (state)
			stFetch: begin
				// load IR and step PC by 4
				ctrl.irWrite = 1'b1;
				ctrl.aluSrcA = srcAPc;
				ctrl.aluSrcB = srcBFour;
				ctrl.aluCtrl = addOnly;
				ctrl.resultSrc = resAluResult;
				ctrl.pcUpdate = 1'b1;
			end
			stDecode: begin
				// branch or jump target into ALUOut
				ctrl.aluSrcA = srcAOldPc;
				ctrl.aluSrcB = srcBImm;
				ctrl.aluCtrl = addOnly;
			end
			stExecuteR: begin
				ctrl.aluSrcA = srcARd1;
				ctrl.aluSrcB = srcBRd2;
				ctrl.aluCtrl = rFunct;
			end
			stExecuteI: begin
				ctrl.aluSrcA = srcARd1;
				ctrl.aluSrcB = srcBImm;
				ctrl.aluCtrl = iFunct;
			end
			stUncondJump: begin
				// PC takes the target, ALU forms the link value
				ctrl.aluSrcA = srcAOldPc;
				ctrl.aluSrcB = srcBFour;
				ctrl.aluCtrl = addOnly;
				ctrl.resultSrc = resAluOut;
				ctrl.pcUpdate = 1'b1;
			end
			stMemAdr: begin
				ctrl.aluSrcA = srcARd1;
				ctrl.aluSrcB = srcBImm;
				ctrl.aluCtrl = addOnly;
			end
			stMemRead: begin
				ctrl.adrSrc = 1'b1;
			end
			stMemWrite: begin
				ctrl.adrSrc = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			stMemWb: begin
				ctrl.resultSrc = resMemData;
				ctrl.regWrite = 1'b1;
			end
			stAluWb: begin
				ctrl.resultSrc = resAluOut;
				ctrl.regWrite = 1'b1;
			end
			stBranchIfEq: begin
				ctrl.aluSrcA = srcARd1;
				ctrl.aluSrcB = srcBRd2;
				ctrl.aluCtrl = branchSub;
				ctrl.resultSrc = resAluOut;
				// only output that looks at an input
				ctrl.pcUpdate = zero;
			end
			default: ctrl = '0;
		endcase
	end

	assign retire = (state == stAluWb) || (state == stMemWb) ||
		(state == stMemWrite) || (state == stBranchIfEq);
	assign idle = (state == stIdle);
	assign illegal = (state == stIllegal);

endmodule

// File: hdl/unifiedMem.sv
/* Unified word memory */
`timescale 1ns/1ps

module unifiedMem #(
	parameter int memWords = 256
) (
	input logic clk,
	input rvIsaPkg::word_t coreAddr,
	input rvIsaPkg::word_t coreWdata,
	input logic coreWe,
	input logic [$clog2(memWords)-1:0] dbgAddr,
	input rvIsaPkg::word_t dbgWdata,
	input logic dbgWe,
	output rvIsaPkg::word_t coreRdata,
	output rvIsaPkg::word_t dbgRdata
);
	import rvIsaPkg::*;

	localparam int addrBits = $clog2(memWords);

	word_t mem [memWords];
	logic [addrBits-1:0] coreIdx;

	// core address is a byte address, drop the byte offset
	assign coreIdx = coreAddr[addrBits+1:2];

	always_ff @(posedge clk) begin
		// debug write wins a collision
		if (dbgWe) begin
			mem[dbgAddr] <= dbgWdata;
		end else if (coreWe) begin
			mem[coreIdx] <= coreWdata;
		end
		coreRdata <= mem[coreIdx];
		dbgRdata <= mem[dbgAddr];
	end

endmodule

// File: hdl/debugRegs.sv
/* APB debug registers */
`timescale 1ns/1ps

module debugRegs #(
	parameter int memWords = 256
) (
	input logic clk,
	input logic reset,
	input rvCtrlPkg::apbReq_t apbReq,
	input logic retire,
	input logic idle,
	input logic illegal,
	input rvIsaPkg::word_t dbgRdata,
	output rvCtrlPkg::apbRsp_t apbRsp,
	output logic run,
	output logic [$clog2(memWords)-1:0] dbgAddr,
	output rvIsaPkg::word_t dbgWdata,
	output logic dbgWe
);
	import rvIsaPkg::*;

	localparam int addrBits = $clog2(memWords);
	localparam logic [7:0] offCtrl = 8'h00;
	localparam logic [7:0] offStatus = 8'h04;
	localparam logic [7:0] offRetired = 8'h08;
	localparam logic [7:0] offMemAddr = 8'h0C;
	localparam logic [7:0] offMemData = 8'h10;

	logic access;
	logic mapped;
	logic memDataRead;
	logic memRdWait;
	logic done;
	logic [addrBits-1:0] winAddr;
	word_t retired;
	logic idleQ;
	logic illegalQ;

	assign access = apbReq.psel & apbReq.penable;
	assign mapped = apbReq.paddr inside {offCtrl, offStatus, offRetired, offMemAddr,
		offMemData};
	assign memDataRead = access & ~apbReq.pwrite & (apbReq.paddr == offMemData);
	// one wait state for window reads
	assign done = access & (~memDataRead | memRdWait);

	always_comb begin
		apbRsp.pready = done;
		apbRsp.pslverr = done & ~mapped;
		case (apbReq.paddr)
			offCtrl: apbRsp.prdata = word_t'(run);
			offStatus: apbRsp.prdata = word_t'({illegalQ, idleQ});
			offRetired: apbRsp.prdata = retired;
			offMemAddr: apbRsp.prdata = word_t'(winAddr);
			offMemData: apbRsp.prdata = dbgRdata;
			default: apbRsp.prdata = '0;
		endcase
	end

	assign dbgAddr = winAddr;
	assign dbgWdata = apbReq.pwdata;
	assign dbgWe = done & apbReq.pwrite & (apbReq.paddr == offMemData);

	always_ff @(posedge clk) begin
		if (reset) begin
			run <= 1'b0;
			winAddr <= '0;
			retired <= '0;
			idleQ <= 1'b1;
			illegalQ <= 1'b0;
			memRdWait <= 1'b0;
		end else begin
			idleQ <= idle;
			illegalQ <= illegal;
			memRdWait <= memDataRead & ~memRdWait;
			if (retire) begin
				retired <= retired + 1'b1;
			end
			if (done & apbReq.pwrite & (apbReq.paddr == offCtrl)) begin
				run <= apbReq.pwdata[0];
				// new run starts a fresh count
				if (apbReq.pwdata[0] & ~run) begin
					retired <= '0;
				end
			end
			if (done & apbReq.pwrite & (apbReq.paddr == offMemAddr)) begin
				winAddr <= addrBits'(apbReq.pwdata % memWords);
			end else if (done & (apbReq.paddr == offMemData)) begin
				winAddr <= (winAddr == addrBits'(memWords - 1)) ? '0 : winAddr + 1'b1;
			end
		end
	end

endmodule

// File: hdl/rvCoreTop.sv
/* RV32I core with debug port */
`timescale 1ns/1ps

module rvCoreTop #(
	parameter int memWords = 256
) (
	input logic clk,
	input logic reset,
	input rvCtrlPkg::apbReq_t apbReq,
	output rvCtrlPkg::apbRsp_t apbRsp
);
	import rvIsaPkg::*;
	import rvCtrlPkg::*;

	ctrlSignals_t ctrl;
	opcode_t opcode;
	logic zero;
	word_t memAddr;
	word_t memWdata;
	logic memWe;
	word_t coreRdata;
	logic run;
	logic retire;
	logic idle;
	logic illegal;
	logic [$clog2(memWords)-1:0] dbgAddr;
	word_t dbgWdata;
	logic dbgWe;
	word_t dbgRdata;

	controlFsm fsm0 (
		.clk(clk),
		.reset(reset),
		.run(run),
		.opcode(opcode),
		.zero(zero),
		.ctrl(ctrl),
		.retire(retire),
		.idle(idle),
		.illegal(illegal)
	);

	// datapath held in reset while idle, so each run starts at PC 0
	coreDatapath dp0 (
		.clk(clk),
		.reset(idle),
		.ctrl(ctrl),
		.memRdata(coreRdata),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memWe(memWe),
		.opcode(opcode),
		.zero(zero)
	);

	unifiedMem #(.memWords(memWords)) mem0 (
		.clk(clk),
		.coreAddr(memAddr),
		.coreWdata(memWdata),
		.coreWe(memWe),
		.dbgAddr(dbgAddr),
		.dbgWdata(dbgWdata),
		.dbgWe(dbgWe),
		.coreRdata(coreRdata),
		.dbgRdata(dbgRdata)
	);

	debugRegs #(.memWords(memWords)) dbg0 (
		.clk(clk),
		.reset(reset),
		.apbReq(apbReq),
		.retire(retire),
		.idle(idle),
		.illegal(illegal),
		.dbgRdata(dbgRdata),
		.apbRsp(apbRsp),
		.run(run),
		.dbgAddr(dbgAddr),
		.dbgWdata(dbgWdata),
		.dbgWe(dbgWe)
	);

endmodule

// File: verif/rvCore_asserts.sv
/* Control FSM assertions */
`timescale 1ns/1ps

module rvCoreAsserts (
	input logic clk,
	input logic reset,
	input rvCtrlPkg::fsmState_t state,
	input rvCtrlPkg::ctrlSignals_t ctrl,
	input logic idle
);
	import rvCtrlPkg::*;

	// IR loads only while fetching
	irWriteInFetch: assert property (@(posedge clk) disable iff (reset)
		ctrl.irWrite |-> state == stFetch)
		else $error("irWrite high outside the fetch state");

	// stores always use the ALUOut address
	memWriteAdr: assert property (@(posedge clk) disable iff (reset)
		ctrl.memWrite |-> ctrl.adrSrc)
		else $error("memWrite high while adrSrc selects the PC");

	regMemExclusive: assert property (@(posedge clk) disable iff (reset)
		!(ctrl.regWrite && ctrl.memWrite))
		else $error("regWrite and memWrite high in the same cycle");

	idleQuiet: assert property (@(posedge clk) disable iff (reset)
		idle |-> ctrl == '0)
		else $error("control outputs active in idle");

endmodule

bind controlFsm rvCoreAsserts asserts0 (
	.clk(clk),
	.reset(reset),
	.state(state),
	.ctrl(ctrl),
	.idle(idle)
);

// File: verif/tbRvCore.sv
/* RV32I core directed testbench */
`timescale 1ns/1ps

module tbRvCore;
	import rvIsaPkg::*;
	import rvCtrlPkg::*;

	localparam int memWords = 256;
	// all tests together take a few thousand cycles
	localparam int cycleLimit = 20000;
	localparam logic [7:0] regCtrl = 8'h00;
	localparam logic [7:0] regStatus = 8'h04;
	localparam logic [7:0] regRetired = 8'h08;
	localparam logic [7:0] regMemAddr = 8'h0C;
	localparam logic [7:0] regMemData = 8'h10;

	logic clk;
	logic reset;
	apbReq_t apbReq;
	apbRsp_t apbRsp;
	apbRsp_t lastRsp;
	int waitCycles;
	int cycleCount = 0;
	int seed;
	word_t wordBuf[$];

	rvCoreTop #(.memWords(memWords)) dut0 (
		.clk(clk),
		.reset(reset),
		.apbReq(apbReq),
		.apbRsp(apbRsp)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic checkWord(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic checkStatus(input logic [1:0] got, input logic [1:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic checkResp(input apbRsp_t rsp, input logic expErr, input string what);
		if (rsp.pslverr !== expErr) begin
			$display("Mismatch at %0t: %s pslverr is %b, expected %b", $time, what,
				rsp.pslverr, expErr);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	// setup phase, then access phase until pready; sampled on the falling edge
	task automatic apbAccess(input logic write, input logic [7:0] addr, input word_t wdata,
		output word_t rdata);
		@(posedge clk);
		apbReq.psel <= 1'b1;
		apbReq.penable <= 1'b0;
		apbReq.pwrite <= write;
		apbReq.paddr <= addr;
		apbReq.pwdata <= wdata;
		@(posedge clk);
		apbReq.penable <= 1'b1;
		waitCycles = 0;
		@(negedge clk);
		while (!apbRsp.pready) begin
			waitCycles++;
			@(negedge clk);
		end
		lastRsp = apbRsp;
		rdata = apbRsp.prdata;
		@(posedge clk);
		apbReq <= '0;
	endtask

	task automatic apbWrite(input logic [7:0] addr, input word_t wdata);
		word_t unused;
		apbAccess(1'b1, addr, wdata, unused);
	endtask

	task automatic apbRead(input logic [7:0] addr, output word_t rdata);
		apbAccess(1'b0, addr, '0, rdata);
	endtask

	// wordBuf goes to consecutive words from base
	task automatic loadWords(input int base);
		apbWrite(regMemAddr, word_t'(base));
		foreach (wordBuf[i]) begin
			apbWrite(regMemData, wordBuf[i]);
		end
	endtask

	task automatic readWord(input int idx, output word_t v);
		apbWrite(regMemAddr, word_t'(idx));
		apbRead(regMemData, v);
	endtask

	task automatic runToIllegal();
		word_t status;
		status = '0;
		apbWrite(regCtrl, 32'd1);
		while (status[1] == 1'b0) begin
			apbRead(regStatus, status);
		end
	endtask

	function automatic word_t sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// instruction assembly
	function automatic word_t encR(input logic [2:0] f3, input logic f7b5, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, rType};
	endfunction

	function automatic word_t encI(input opcode_t op, input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t encS(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], sType};
	endfunction

	function automatic word_t encB(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], bType};
	endfunction

	function automatic word_t encJ(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, jType};
	endfunction

	task automatic testRegsAndWindow();
		word_t v;
		word_t pattern [3];
		apbRead(regCtrl, v);
		checkWord(v, '0, "CTRL after reset");
		apbRead(regStatus, v);
		checkStatus(v[1:0], 2'b01, "STATUS after reset");
		apbRead(regRetired, v);
		checkWord(v, '0, "RETIRED after reset");
		checkResp(lastRsp, 1'b0, "RETIRED read");
		checkWord(word_t'(waitCycles), '0, "register read wait states");
		apbWrite(regMemAddr, 32'd10);
		for (int i = 0; i < 3; i++) begin
			pattern[i] = $random(seed);
			apbWrite(regMemData, pattern[i]);
		end
		apbRead(regMemAddr, v);
		checkWord(v, 32'd13, "MEMADDR after window writes");
		apbWrite(regMemAddr, 32'd10);
		for (int i = 0; i < 3; i++) begin
			apbRead(regMemData, v);
			checkWord(v, pattern[i], "MEMDATA read back");
			checkWord(word_t'(waitCycles), 32'd1, "MEMDATA read wait states");
		end
		apbRead(regMemAddr, v);
		checkWord(v, 32'd13, "MEMADDR after window reads");
		// window wraps at the top of memory
		apbWrite(regMemAddr, word_t'(memWords - 1));
		apbWrite(regMemData, 32'h5a5a_0ff0);
		apbRead(regMemAddr, v);
		checkWord(v, '0, "MEMADDR after wrap");
		apbRead(8'h20, v);
		checkResp(lastRsp, 1'b1, "read of unmapped 0x20");
		apbWrite(8'h14, 32'h1234);
		checkResp(lastRsp, 1'b1, "write of unmapped 0x14");
	endtask

	task automatic testAluProgram();
		word_t a;
		word_t b;
		word_t v;
		logic [11:0] immA;
		logic [11:0] immB;
		logic [11:0] immC;
		word_t expVal [8];
		a = $random(seed);
		b = $random(seed);
		immA = 12'($random(seed));
		immB = 12'($random(seed));
		immC = 12'($random(seed));
		expVal[0] = a + b;
		expVal[1] = a - b;
		expVal[2] = a & b;
		expVal[3] = a | b;
		expVal[4] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		expVal[5] = a + sext12(immA);
		expVal[6] = a & sext12(immB);
		expVal[7] = b | sext12(immC);
		wordBuf = '{a, b};
		loadWords(64);
		wordBuf.delete();
		wordBuf.push_back(encI(iTypeLoad, 3'b010, 5'd1, 5'd0, 12'd256));
		wordBuf.push_back(encI(iTypeLoad, 3'b010, 5'd2, 5'd0, 12'd260));
		wordBuf.push_back(encR(f3AddSub, 1'b0, 5'd3, 5'd1, 5'd2));
		wordBuf.push_back(encR(f3AddSub, 1'b1, 5'd4, 5'd1, 5'd2));
		wordBuf.push_back(encR(f3And, 1'b0, 5'd5, 5'd1, 5'd2));
		wordBuf.push_back(encR(f3Or, 1'b0, 5'd6, 5'd1, 5'd2));
		wordBuf.push_back(encR(f3Slt, 1'b0, 5'd7, 5'd1, 5'd2));
		wordBuf.push_back(encI(iTypeLogic, f3AddSub, 5'd8, 5'd1, immA));
		wordBuf.push_back(encI(iTypeLogic, f3And, 5'd9, 5'd1, immB));
		wordBuf.push_back(encI(iTypeLogic, f3Or, 5'd10, 5'd2, immC));
		// results x3..x10 go to word 96 onward
		for (int r = 0; r < 8; r++) begin
			wordBuf.push_back(encS(5'd0, 5'(r + 3), 12'(384 + 4 * r)));
		end
		wordBuf.push_back('0);
		loadWords(0);
		runToIllegal();
		for (int r = 0; r < 8; r++) begin
			readWord(96 + r, v);
			checkWord(v, expVal[r], "ALU program result");
		end
		apbWrite(regCtrl, '0);
	endtask

	task automatic testBlockCopy();
		word_t src [4];
		word_t v;
		wordBuf.delete();
		for (int i = 0; i < 4; i++) begin
			src[i] = $random(seed);
			wordBuf.push_back(src[i]);
		end
		loadWords(128);
		wordBuf = '{32'd0, 32'd0, 32'd0, 32'd0};
		loadWords(160);
		wordBuf.delete();
		wordBuf.push_back(encI(iTypeLogic, f3AddSub, 5'd1, 5'd0, 12'd512));
		wordBuf.push_back(encI(iTypeLogic, f3AddSub, 5'd2, 5'd0, 12'd640));
		for (int i = 0; i < 4; i++) begin
			wordBuf.push_back(encI(iTypeLoad, 3'b010, 5'd3, 5'd1, 12'(4 * i)));
			wordBuf.push_back(encS(5'd2, 5'd3, 12'(4 * i)));
		end
		wordBuf.push_back('0);
		loadWords(0);
		runToIllegal();
		for (int i = 0; i < 4; i++) begin
			readWord(160 + i, v);
			checkWord(v, src[i], "copied block word");
		end
		apbWrite(regCtrl, '0);
	endtask

	// leaves the core stopped in the illegal state
	task automatic testCountdownLoop(output int expRetired, output word_t expSum);
		int n;
		word_t v;
		n = ($random(seed) & 7) + 1;
		wordBuf.delete();
		wordBuf.push_back(encI(iTypeLogic, f3AddSub, 5'd1, 5'd0, 12'(n)));
		wordBuf.push_back(encI(iTypeLogic, f3AddSub, 5'd2, 5'd0, 12'd0));
		wordBuf.push_back(encB(5'd1, 5'd0, 13'd16));
		wordBuf.push_back(encI(iTypeLogic, f3AddSub, 5'd2, 5'd2, 12'd3));
		wordBuf.push_back(encI(iTypeLogic, f3AddSub, 5'd1, 5'd1, 12'hfff));
		wordBuf.push_back(encJ(5'd5, 21'(-12)));
		wordBuf.push_back(encS(5'd0, 5'd2, 12'd384));
		wordBuf.push_back(encS(5'd0, 5'd5, 12'd388));
		wordBuf.push_back('0);
		loadWords(0);
		// two setup addi, then beq, addi, addi, jal per pass
		expRetired = 2;
		for (int i = 0; i < n; i++) begin
			expRetired += 4;
		end
		// taken beq and the two stores
		expRetired += 3;
		expSum = word_t'(3 * n);
		runToIllegal();
		readWord(96, v);
		checkWord(v, expSum, "countdown sum");
		readWord(97, v);
		checkWord(v, 32'd24, "jal link value");
		apbRead(regRetired, v);
		checkWord(v, word_t'(expRetired), "RETIRED after countdown");
	endtask

	task automatic testIllegalRestart(input int expRetired, input word_t expSum);
		word_t v;
		word_t first;
		apbRead(regStatus, v);
		checkStatus(v[1:0], 2'b10, "STATUS while illegal");
		apbRead(regRetired, first);
		// quiet interval, nothing may retire
		repeat (20) @(posedge clk);
		apbRead(regRetired, v);
		checkWord(v, first, "RETIRED after illegal stop");
		apbWrite(regCtrl, '0);
		apbRead(regStatus, v);
		checkStatus(v[1:0], 2'b01, "STATUS after run cleared");
		wordBuf = '{32'd0, 32'd0};
		loadWords(96);
		apbWrite(regCtrl, 32'd1);
		apbRead(regCtrl, v);
		checkWord(v, 32'd1, "CTRL after restart");
		runToIllegal();
		apbRead(regRetired, v);
		checkWord(v, word_t'(expRetired), "RETIRED after restart");
		readWord(96, v);
		checkWord(v, expSum, "countdown sum after restart");
		readWord(97, v);
		checkWord(v, 32'd24, "jal link value after restart");
		apbWrite(regCtrl, '0);
	endtask

	initial begin
		int expRetired;
		word_t expSum;
		clk = 1'b0;
		reset = 1'b1;
		apbReq = '0;
		seed = 32'h90ea;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		testRegsAndWindow();
		testAluProgram();
		testBlockCopy();
		testCountdownLoop(expRetired, expSum);
		testIllegalRestart(expRetired, expSum);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: build.f
hdl/rvIsaPkg.sv
hdl/rvCtrlPkg.sv
hdl/aluUnit.sv
hdl/regFile.sv
hdl/coreDatapath.sv
hdl/controlFsm.sv
hdl/unifiedMem.sv
hdl/debugRegs.sv
hdl/rvCoreTop.sv
verif/rvCore_asserts.sv
verif/tbRvCore.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tbRvCore -f build.f -o simRvCore \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/simRvCore > sim.log 2>&1 || echo "simulation exited with an error: TESTBENCH FAILED" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
